// ==== bench/tb_top_s.sv ====
// testbench for the acquisition slice
`default_nettype none

module tb_top_s;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_DIV       = 2;
  localparam int NS_PER_CLK    = 100;
  localparam int CLK_PERIOD    = 100;
  localparam int FRAME_CYC     = 52 * CLK_DIV;
  localparam int SETS_PER_MODE = 3;
  localparam int PLAN_FRAMES   = 4 * SETS_PER_MODE + 4;
  localparam int MAX_FRAMES    = PLAN_FRAMES + 4;
  localparam int WATCHDOG_CYC  = PLAN_FRAMES * FRAME_CYC + 2000;

  logic                    clk_sys;
  logic                    reset;
  wz_cfg_pkg::apb_addr_t   paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  wz_cfg_pkg::apb_data_t   pwdata;
  wz_cfg_pkg::apb_data_t   prdata;
  logic                    pready;
  logic                    rx_syn;
  wire [2:0]               adc_clk;
  wire [2:0]               adc_sync;
  logic [2:0]              adc_din;
  wz_data_pkg::dp_sample_t dp_data;
  logic                    dp_vld;
  wz_data_pkg::utc_t       dp_sec;
  wz_data_pkg::ns_t        dp_ns;

  int                      edge_cnt = 0;
  int                      clear_edge;
  int                      rd_edge;
  int                      set_cnt;
  int                      sent_cnt [3];
  logic [31:0]             lfsr_q;
  logic [1:0]              exp_mode;
  wz_data_pkg::utc_t       exp_sec;
  wz_data_pkg::ad_sample_t sample_tab [3][MAX_FRAMES];

  top_s #(.CLK_DIV(CLK_DIV), .NS_PER_CLK(NS_PER_CLK)) u_dut (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .rx_syn   (rx_syn),
    .ad1_clk  (adc_clk[0]),
    .ad2_clk  (adc_clk[1]),
    .ad3_clk  (adc_clk[2]),
    .ad1_din  (adc_din[0]),
    .ad2_din  (adc_din[1]),
    .ad3_din  (adc_din[2]),
    .ad1_sync (adc_sync[0]),
    .ad2_sync (adc_sync[1]),
    .ad3_sync (adc_sync[2]),
    .dp_data  (dp_data),
    .dp_vld   (dp_vld),
    .dp_sec   (dp_sec),
    .dp_ns    (dp_ns)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) edge_cnt <= edge_cnt + 1;

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    stop_run("timeout: the test did not finish within the allowed number of cycles");
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  // right-shift galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = galois_step(lfsr_q);
    end
  endtask

  function automatic wz_cfg_pkg::mod_t ad_module(input int ch);
    case (ch)
      0:       return wz_cfg_pkg::MOD_AD1;
      1:       return wz_cfg_pkg::MOD_AD2;
      default: return wz_cfg_pkg::MOD_AD3;
    endcase
  endfunction

  task automatic check_bus(input string what, input wz_cfg_pkg::apb_data_t got,
                           input wz_cfg_pkg::apb_data_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0d ns: %s read %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_sample(input wz_data_pkg::dp_sample_t got,
                              input wz_data_pkg::dp_sample_t exp);
    if (got !== exp)
      stop_run($sformatf("Error at %0d ns: dp_data %h, expected %h", $time, got, exp));
  endtask

  task automatic check_time(input wz_data_pkg::utc_t got_sec, input wz_data_pkg::ns_t got_ns,
                            input wz_data_pkg::utc_t exp_sec, input wz_data_pkg::ns_t exp_ns);
    if (got_sec !== exp_sec || got_ns !== exp_ns)
      stop_run($sformatf("Error at %0d ns: time %0d s %0d ns, expected %0d s %0d ns",
                         $time, got_sec, got_ns, exp_sec, exp_ns));
  endtask

  // setup then access, done on the edge with pready high
  task automatic apb_xfer(input logic write, input wz_cfg_pkg::apb_addr_t addr,
                          input wz_cfg_pkg::apb_data_t wdata,
                          output wz_cfg_pkg::apb_data_t rdata);
    int waits;
    waits = 0;
    @(posedge clk_sys);
    #10;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk_sys);
    #10;
    penable = 1'b1;
    @(negedge clk_sys);
    while (pready !== 1'b1) begin
      waits++;
      if (waits > 8) stop_run("register bus transfer never completed");
      @(negedge clk_sys);
    end
    rdata   = prdata;
    rd_edge = edge_cnt;
    @(posedge clk_sys);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input wz_cfg_pkg::mod_t m, input wz_cfg_pkg::reg_t r,
                           input wz_cfg_pkg::apb_data_t d);
    wz_cfg_pkg::apb_data_t unused;
    apb_xfer(1'b1, {m, r}, d, unused);
  endtask

  task automatic reg_read(input wz_cfg_pkg::mod_t m, input wz_cfg_pkg::reg_t r,
                          output wz_cfg_pkg::apb_data_t d);
    apb_xfer(1'b0, {m, r}, '0, d);
  endtask

  // first sampling edge is the next one, now_ns clears three edges later
  task automatic pulse_sync();
    @(posedge clk_sys);
    #10;
    rx_syn     = 1'b1;
    clear_edge = edge_cnt + 4;
    repeat (3) @(posedge clk_sys);
    #10;
    rx_syn = 1'b0;
    wait (edge_cnt >= clear_edge);
  endtask

  // --------------------------------------------------------------------------
  // adc models, din changes after each falling ad_clk
  // --------------------------------------------------------------------------
  initial begin
    logic [2:0]              prev_clk;
    int                      bits_left [3];
    wz_data_pkg::ad_sample_t word [3];
    prev_clk = '0;
    adc_din  = '0;
    for (int g = 0; g < 3; g++) begin
      sent_cnt[g]  = 0;
      bits_left[g] = 0;
      word[g]      = '0;
    end
    forever begin
      @(posedge clk_sys);
      #10;
      for (int g = 0; g < 3; g++) begin
        if (prev_clk[g] && !adc_clk[g]) begin
          if (adc_sync[g]) begin
            if (sent_cnt[g] >= MAX_FRAMES) stop_run("adc model ran out of prepared samples");
            word[g]      = sample_tab[g][sent_cnt[g]];
            bits_left[g] = 24;
            sent_cnt[g]++;
          end
          if (bits_left[g] > 0) begin
            adc_din[g]   = word[g][23];
            word[g]      = word[g] << 1;
            bits_left[g]--;
          end
        end
        prev_clk[g] = adc_clk[g];
      end
    end
  end

  // --------------------------------------------------------------------------
  // combine and timestamp reference
  // --------------------------------------------------------------------------
  initial begin
    int                      sum;
    wz_data_pkg::ns_t        exp_ns;
    set_cnt = 0;
    forever begin
      @(negedge clk_sys);
      if (dp_vld === 1'b1) begin
        if (sent_cnt[0] <= set_cnt || sent_cnt[1] <= set_cnt || sent_cnt[2] <= set_cnt)
          stop_run("combined sample appeared before every channel had sent one");
        case (exp_mode)
          2'd0:    sum = int'(sample_tab[0][set_cnt]);
          2'd1:    sum = int'(sample_tab[1][set_cnt]);
          2'd2:    sum = int'(sample_tab[2][set_cnt]);
          default: sum = int'(sample_tab[0][set_cnt]) + int'(sample_tab[1][set_cnt]) +
                         int'(sample_tab[2][set_cnt]);
        endcase
        // set completed one cycle before dp_vld
        exp_ns = (edge_cnt - 1 - clear_edge) * NS_PER_CLK;
        check_sample(dp_data, sum[25:0]);
        check_time(dp_sec, dp_ns, exp_sec, exp_ns);
        set_cnt++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------
  initial begin
    wz_cfg_pkg::apb_data_t rd;
    wz_cfg_pkg::apb_data_t rd_ns;
    logic [31:0]           v;
    wz_data_pkg::utc_t     sec_val;
    int                    sx;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    rx_syn     = 1'b0;
    reset      = 1'b1;
    lfsr_q     = 32'd48;
    exp_mode   = 2'd0;
    exp_sec    = '0;
    clear_edge = 0;
    for (int g = 0; g < 3; g++) begin
      for (int f = 0; f < MAX_FRAMES; f++) begin
        draw_bits(24, v);
        sample_tab[g][f] = v[23:0];
      end
    end

    repeat (10) @(posedge clk_sys);
    #10;
    reset = 1'b0;
    @(negedge clk_sys);
    if (dp_vld !== 1'b0 || pready !== 1'b0 || adc_clk !== 3'b0 || adc_sync !== 3'b0)
      stop_run("an output was not low after reset");
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_STAT, rd);
    check_bus("syn status after reset", rd, '0);

    // register access, enables stay off here
    for (int i = 0; i < 4; i++) begin
      draw_bits(32, v);
      reg_write(wz_cfg_pkg::MOD_DSP, wz_cfg_pkg::REG_CTRL, v);
      reg_read(wz_cfg_pkg::MOD_DSP, wz_cfg_pkg::REG_CTRL, rd);
      check_bus("dsp control", rd, {30'b0, v[1:0]});
    end
    for (int g = 0; g < 3; g++) begin
      draw_bits(32, v);
      reg_write(ad_module(g), wz_cfg_pkg::REG_CTRL, {v[31:1], 1'b0});
      reg_read(ad_module(g), wz_cfg_pkg::REG_CTRL, rd);
      check_bus("adc control", rd, '0);
    end
    reg_write(4'd9, wz_cfg_pkg::REG_CTRL, 32'hFFFF_FFFF);
    reg_read(4'd9, wz_cfg_pkg::REG_CTRL, rd);
    check_bus("unmapped module", rd, '0);

    // seconds load on the first sync edge
    draw_bits(32, v);
    sec_val = v;
    reg_write(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_CTRL, sec_val);
    pulse_sync();
    exp_sec = sec_val;
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_CTRL, rd);
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_DATA, rd_ns);
    check_time(rd, rd_ns, sec_val, (rd_edge - clear_edge) * NS_PER_CLK);
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_STAT, rd);
    check_bus("syn status after sync", rd, 32'd1);

    // capture and combine, mode changes just after a set
    for (int m = 0; m < 4; m++) begin
      draw_bits(32, v);
      reg_write(wz_cfg_pkg::MOD_DSP, wz_cfg_pkg::REG_CTRL, {v[31:2], 2'(m)});
      exp_mode = 2'(m);
      if (m == 0) begin
        for (int g = 0; g < 3; g++) begin
          draw_bits(32, v);
          reg_write(ad_module(g), wz_cfg_pkg::REG_CTRL, {v[31:1], 1'b1});
        end
        for (int g = 0; g < 3; g++) begin
          reg_read(ad_module(g), wz_cfg_pkg::REG_CTRL, rd);
          check_bus("adc enable", rd, 32'd1);
        end
      end
      wait (set_cnt >= (m + 1) * SETS_PER_MODE);
    end
    for (int g = 0; g < 3; g++) reg_write(ad_module(g), wz_cfg_pkg::REG_CTRL, '0);
    // a running frame always finishes within one frame length
    repeat (2 * FRAME_CYC) @(posedge clk_sys);

    for (int g = 0; g < 3; g++) begin
      if (sent_cnt[g] != set_cnt) stop_run("channel frame count differs from combined outputs");
      sx = int'(sample_tab[g][sent_cnt[g] - 1]);
      reg_read(ad_module(g), wz_cfg_pkg::REG_DATA, rd);
      check_bus("adc sample", rd, sx);
      reg_read(ad_module(g), wz_cfg_pkg::REG_STAT, rd);
      check_bus("adc frame count", rd, sent_cnt[g]);
    end
    reg_read(wz_cfg_pkg::MOD_DSP, wz_cfg_pkg::REG_STAT, rd);
    check_bus("dsp output count", rd, set_cnt);

    // second edge without a pending value
    pulse_sync();
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_CTRL, rd);
    reg_read(wz_cfg_pkg::MOD_SYN, wz_cfg_pkg::REG_DATA, rd_ns);
    check_time(rd, rd_ns, sec_val + 32'd1, (rd_edge - clear_edge) * NS_PER_CLK);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/wz_cfg_pkg.sv
logic/wz_data_pkg.sv
logic/fx_apb_if.sv
logic/fx_apb_fabric.sv
logic/syn_timebase.sv
logic/ad_capture.sv
logic/dsp_combine.sv
logic/top_s.sv
bench/tb_top_s.sv

// ==== logic/ad_capture.sv ====
// serial adc frame sequencer and capture
`default_nettype none

module ad_capture #(
  parameter int CLK_DIV = 2
) (
  input  logic                    clk_sys,
  input  logic                    reset,
  output logic                    ad_clk,
  input  logic                    ad_din,
  output logic                    ad_sync,
  fx_apb_if.target                bus,
  output wz_data_pkg::ad_sample_t ad_sample,
  output logic                    ad_vld
);

  // half period 0 opens a frame, 51 closes it
  localparam logic [5:0]  HALF_LAST = 6'd51;
  localparam logic [5:0]  HALF_LSB  = 6'd48;
  localparam logic [15:0] DIV_LAST  = 16'(CLK_DIV - 1);

  logic        en;
  logic        running;
  logic        start;
  logic        adv;
  logic [15:0] div_cnt;
  logic [5:0]  half_cnt;
  logic [5:0]  half_nxt;
  logic        take_bit;
  logic [22:0] shift_q;
  logic [15:0] frame_cnt;
  logic        ctrl_wr;

  assign ctrl_wr = bus.psel & bus.penable & bus.pwrite &
                   (bus.paddr[3:0] == wz_cfg_pkg::REG_CTRL);

  assign start    = en & ~running;
  assign adv      = running & (div_cnt == DIV_LAST);
  assign half_nxt = (half_cnt == HALF_LAST) ? 6'd0 : half_cnt + 6'd1;
  // each data period begins with a rising ad_clk
  assign take_bit = adv & ~half_nxt[0] & (half_nxt >= 6'd2) & (half_nxt <= HALF_LSB);

  // -------------------------------------------------------------------------
  // frame sequencer
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      en        <= 1'b0;
      running   <= 1'b0;
      div_cnt   <= '0;
      half_cnt  <= '0;
      ad_clk    <= 1'b0;
      ad_sync   <= 1'b0;
      ad_vld    <= 1'b0;
      frame_cnt <= '0;
    end else begin
      ad_vld <= 1'b0;
      if (ctrl_wr) en <= bus.pwdata[0];
      if (start) begin
        running  <= 1'b1;
        div_cnt  <= '0;
        half_cnt <= '0;
        ad_clk   <= 1'b1;
        ad_sync  <= 1'b1;
      end else if (running) begin
        if (!adv) begin
          div_cnt <= div_cnt + 16'd1;
        end else begin
          div_cnt <= '0;
          if (half_cnt == HALF_LAST && !en) begin
            // disabled, park after the idle period
            running <= 1'b0;
            ad_clk  <= 1'b0;
            ad_sync <= 1'b0;
          end else begin
            half_cnt <= half_nxt;
            ad_clk   <= ~half_nxt[0];
            ad_sync  <= (half_nxt <= 6'd1);
            if (half_nxt == HALF_LSB) begin
              ad_vld    <= 1'b1;
              frame_cnt <= frame_cnt + 16'd1;
            end
          end
        end
      end
    end
  end

  // msb first shift, full word on the last bit
  always_ff @(posedge clk_sys) begin
    if (take_bit) shift_q <= {shift_q[21:0], ad_din};
    if (take_bit && half_nxt == HALF_LSB) ad_sample <= {shift_q, ad_din};
  end

  assign bus.pready = bus.psel & bus.penable;

  always_comb begin
    case (bus.paddr[3:0])
      wz_cfg_pkg::REG_CTRL: bus.prdata = {31'b0, en};
      wz_cfg_pkg::REG_DATA: bus.prdata = {{8{ad_sample[23]}}, ad_sample};
      wz_cfg_pkg::REG_STAT: bus.prdata = {16'b0, frame_cnt};
      default:              bus.prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/dsp_combine.sv ====
// three channel combine with timestamp
`default_nettype none

module dsp_combine (
  input  logic                    clk_sys,
  input  logic                    reset,
  input  wz_data_pkg::ad_sample_t ad1_sample,
  input  wz_data_pkg::ad_sample_t ad2_sample,
  input  wz_data_pkg::ad_sample_t ad3_sample,
  input  logic                    ad1_vld,
  input  logic                    ad2_vld,
  input  logic                    ad3_vld,
  input  wz_data_pkg::utc_t       utc_sec,
  input  wz_data_pkg::ns_t        now_ns,
  fx_apb_if.target                bus,
  output wz_data_pkg::dp_sample_t dp_data,
  output logic                    dp_vld,
  output wz_data_pkg::utc_t       dp_sec,
  output wz_data_pkg::ns_t        dp_ns
);

  wz_data_pkg::ad_sample_t s1_q, s2_q, s3_q;
  wz_data_pkg::ad_sample_t s1, s2, s3;
  wz_data_pkg::dp_sample_t ext1, ext2, ext3;
  wz_data_pkg::dp_sample_t comb;
  wz_data_pkg::dp_mode_t   mode;
  logic [2:0]              have_q;
  logic [2:0]              have;
  logic                    all_have;
  logic [31:0]             out_cnt;
  logic                    ctrl_wr;

  assign ctrl_wr = bus.psel & bus.penable & bus.pwrite &
                   (bus.paddr[3:0] == wz_cfg_pkg::REG_CTRL);

  // a sample arriving this cycle counts already
  assign s1       = ad1_vld ? ad1_sample : s1_q;
  assign s2       = ad2_vld ? ad2_sample : s2_q;
  assign s3       = ad3_vld ? ad3_sample : s3_q;
  assign have     = have_q | {ad3_vld, ad2_vld, ad1_vld};
  assign all_have = &have;

  assign ext1 = {{2{s1[23]}}, s1};
  assign ext2 = {{2{s2[23]}}, s2};
  assign ext3 = {{2{s3[23]}}, s3};

  always_comb begin
    case (mode)
      wz_data_pkg::DP_CH1: comb = ext1;
      wz_data_pkg::DP_CH2: comb = ext2;
      wz_data_pkg::DP_CH3: comb = ext3;
      default:             comb = ext1 + ext2 + ext3;
    endcase
  end

  // -------------------------------------------------------------------------
  // set tracking and output
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      have_q  <= '0;
      dp_vld  <= 1'b0;
      mode    <= wz_data_pkg::DP_CH1;
      out_cnt <= '0;
    end else begin
      dp_vld <= all_have;
      if (all_have) begin
        have_q  <= '0;
        out_cnt <= out_cnt + 32'd1;
      end else begin
        have_q <= have;
      end
      if (ctrl_wr) mode <= wz_data_pkg::dp_mode_t'(bus.pwdata[1:0]);
    end
  end

  // newest sample wins until the set completes
  always_ff @(posedge clk_sys) begin
    if (ad1_vld) s1_q <= ad1_sample;
    if (ad2_vld) s2_q <= ad2_sample;
    if (ad3_vld) s3_q <= ad3_sample;
    if (all_have) begin
      dp_data <= comb;
      dp_sec  <= utc_sec;
      dp_ns   <= now_ns;
    end
  end

  assign bus.pready = bus.psel & bus.penable;

  always_comb begin
    case (bus.paddr[3:0])
      wz_cfg_pkg::REG_CTRL: bus.prdata = {30'b0, mode};
      wz_cfg_pkg::REG_DATA: bus.prdata = {{6{dp_data[25]}}, dp_data};
      wz_cfg_pkg::REG_STAT: bus.prdata = out_cnt;
      default:              bus.prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fx_apb_fabric.sv ====
// register bus fabric, routes by module number
`default_nettype none

module fx_apb_fabric (
  fx_apb_if.target host,
  fx_apb_if.host   syn,
  fx_apb_if.host   ad1,
  fx_apb_if.host   ad2,
  fx_apb_if.host   ad3,
  fx_apb_if.host   dsp
);

  wz_cfg_pkg::mod_t      mod;
  wz_cfg_pkg::apb_addr_t blk_addr;

  assign mod      = host.paddr[7:4];
  assign blk_addr = {4'h0, host.paddr[3:0]};

  // -------------------------------------------------------------------------
  // request side
  // -------------------------------------------------------------------------
  assign syn.psel = host.psel && (mod == wz_cfg_pkg::MOD_SYN);
  assign ad1.psel = host.psel && (mod == wz_cfg_pkg::MOD_AD1);
  assign ad2.psel = host.psel && (mod == wz_cfg_pkg::MOD_AD2);
  assign ad3.psel = host.psel && (mod == wz_cfg_pkg::MOD_AD3);
  assign dsp.psel = host.psel && (mod == wz_cfg_pkg::MOD_DSP);

  assign syn.paddr = blk_addr;
  assign ad1.paddr = blk_addr;
  assign ad2.paddr = blk_addr;
  assign ad3.paddr = blk_addr;
  assign dsp.paddr = blk_addr;

  assign syn.penable = host.penable;
  assign ad1.penable = host.penable;
  assign ad2.penable = host.penable;
  assign ad3.penable = host.penable;
  assign dsp.penable = host.penable;

  assign syn.pwrite = host.pwrite;
  assign ad1.pwrite = host.pwrite;
  assign ad2.pwrite = host.pwrite;
  assign ad3.pwrite = host.pwrite;
  assign dsp.pwrite = host.pwrite;

  assign syn.pwdata = host.pwdata;
  assign ad1.pwdata = host.pwdata;
  assign ad2.pwdata = host.pwdata;
  assign ad3.pwdata = host.pwdata;
  assign dsp.pwdata = host.pwdata;

  // -------------------------------------------------------------------------
  // response side
  // -------------------------------------------------------------------------
  always_comb begin
    // unmapped numbers finish at once with zero data
    host.prdata = '0;
    host.pready = host.psel & host.penable;
    case (mod)
      wz_cfg_pkg::MOD_SYN: begin
        host.prdata = syn.prdata;
        host.pready = syn.pready;
      end
      wz_cfg_pkg::MOD_AD1: begin
        host.prdata = ad1.prdata;
        host.pready = ad1.pready;
      end
      wz_cfg_pkg::MOD_AD2: begin
        host.prdata = ad2.prdata;
        host.pready = ad2.pready;
      end
      wz_cfg_pkg::MOD_AD3: begin
        host.prdata = ad3.prdata;
        host.pready = ad3.pready;
      end
      wz_cfg_pkg::MOD_DSP: begin
        host.prdata = dsp.prdata;
        host.pready = dsp.pready;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/fx_apb_if.sv ====
// register bus, apb flavour
`default_nettype none

interface fx_apb_if;

  wz_cfg_pkg::apb_addr_t paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  wz_cfg_pkg::apb_data_t pwdata;
  wz_cfg_pkg::apb_data_t prdata;
  logic                  pready;

  modport host (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready
  );

  modport target (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready
  );

endinterface

`default_nettype wire

// ==== logic/syn_timebase.sv ====
// seconds and nanoseconds timebase
`default_nettype none

module syn_timebase #(
  parameter int NS_PER_CLK = 100
) (
  input  logic              clk_sys,
  input  logic              reset,
  input  logic              rx_syn,
  fx_apb_if.target          bus,
  output wz_data_pkg::utc_t utc_sec,
  output wz_data_pkg::ns_t  now_ns
);

  logic [2:0]        syn_sr;
  logic              syn_evt;
  logic              syn_vld;
  logic              pend_vld;
  wz_data_pkg::utc_t pend_sec;
  wz_data_pkg::ns_t  ns_next;
  logic              ctrl_wr;

  assign ctrl_wr = bus.psel & bus.penable & bus.pwrite &
                   (bus.paddr[3:0] == wz_cfg_pkg::REG_CTRL);
  assign ns_next = now_ns + wz_data_pkg::ns_t'(NS_PER_CLK);

  // two-flop synchronizer, one more stage for the rising edge
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      syn_sr  <= '0;
      syn_evt <= 1'b0;
    end else begin
      syn_sr  <= {syn_sr[1:0], rx_syn};
      syn_evt <= syn_sr[1] & ~syn_sr[2];
    end
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      utc_sec  <= '0;
      now_ns   <= '0;
      syn_vld  <= 1'b0;
      pend_vld <= 1'b0;
    end else begin
      if (syn_evt) begin
        now_ns   <= '0;
        utc_sec  <= pend_vld ? pend_sec : utc_sec + 32'd1;
        syn_vld  <= 1'b1;
        pend_vld <= 1'b0;
      end else if (ns_next >= wz_data_pkg::NS_PER_SEC) begin
        now_ns  <= '0;
        utc_sec <= utc_sec + 32'd1;
      end else begin
        now_ns <= ns_next;
      end
      // a write in the same cycle arms the next edge
      if (ctrl_wr) pend_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (ctrl_wr) pend_sec <= bus.pwdata;
  end

  assign bus.pready = bus.psel & bus.penable;

  always_comb begin
    case (bus.paddr[3:0])
      wz_cfg_pkg::REG_CTRL: bus.prdata = utc_sec;
      wz_cfg_pkg::REG_DATA: bus.prdata = now_ns;
      wz_cfg_pkg::REG_STAT: bus.prdata = {31'b0, syn_vld};
      default:              bus.prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/top_s.sv ====
// acquisition slice of the slave fpga
`default_nettype none

module top_s #(
  parameter int CLK_DIV    = 2,
  parameter int NS_PER_CLK = 100
) (
  input  logic                    clk_sys,
  input  logic                    reset,
  // register bus
  input  wz_cfg_pkg::apb_addr_t   paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  wz_cfg_pkg::apb_data_t   pwdata,
  output wz_cfg_pkg::apb_data_t   prdata,
  output logic                    pready,
  // sync line
  input  logic                    rx_syn,
  // adc interface
  output logic                    ad1_clk,
  output logic                    ad2_clk,
  output logic                    ad3_clk,
  input  logic                    ad1_din,
  input  logic                    ad2_din,
  input  logic                    ad3_din,
  output logic                    ad1_sync,
  output logic                    ad2_sync,
  output logic                    ad3_sync,
  // combined data out
  output wz_data_pkg::dp_sample_t dp_data,
  output logic                    dp_vld,
  output wz_data_pkg::utc_t       dp_sec,
  output wz_data_pkg::ns_t        dp_ns
);

  // -------------------------------------------------------------------------
  // register bus
  // -------------------------------------------------------------------------
  fx_apb_if host_bus ();
  fx_apb_if syn_bus ();
  fx_apb_if ad1_bus ();
  fx_apb_if ad2_bus ();
  fx_apb_if ad3_bus ();
  fx_apb_if dsp_bus ();

  assign host_bus.paddr   = paddr;
  assign host_bus.psel    = psel;
  assign host_bus.penable = penable;
  assign host_bus.pwrite  = pwrite;
  assign host_bus.pwdata  = pwdata;
  assign prdata           = host_bus.prdata;
  assign pready           = host_bus.pready;

  fx_apb_fabric u_fx_apb_fabric (
    .host (host_bus),
    .syn  (syn_bus),
    .ad1  (ad1_bus),
    .ad2  (ad2_bus),
    .ad3  (ad3_bus),
    .dsp  (dsp_bus)
  );

  // -------------------------------------------------------------------------
  // timebase
  // -------------------------------------------------------------------------
  wz_data_pkg::utc_t utc_sec;
  wz_data_pkg::ns_t  now_ns;

  syn_timebase #(.NS_PER_CLK(NS_PER_CLK)) u_syn_timebase (
    .clk_sys (clk_sys),
    .reset   (reset),
    .rx_syn  (rx_syn),
    .bus     (syn_bus),
    .utc_sec (utc_sec),
    .now_ns  (now_ns)
  );

  // -------------------------------------------------------------------------
  // adc channels
  // -------------------------------------------------------------------------
  wz_data_pkg::ad_sample_t ad1_sample, ad2_sample, ad3_sample;
  logic                    ad1_vld, ad2_vld, ad3_vld;

  ad_capture #(.CLK_DIV(CLK_DIV)) u_ad1_capture (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .ad_clk    (ad1_clk),
    .ad_din    (ad1_din),
    .ad_sync   (ad1_sync),
    .bus       (ad1_bus),
    .ad_sample (ad1_sample),
    .ad_vld    (ad1_vld)
  );

  ad_capture #(.CLK_DIV(CLK_DIV)) u_ad2_capture (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .ad_clk    (ad2_clk),
    .ad_din    (ad2_din),
    .ad_sync   (ad2_sync),
    .bus       (ad2_bus),
    .ad_sample (ad2_sample),
    .ad_vld    (ad2_vld)
  );

  ad_capture #(.CLK_DIV(CLK_DIV)) u_ad3_capture (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .ad_clk    (ad3_clk),
    .ad_din    (ad3_din),
    .ad_sync   (ad3_sync),
    .bus       (ad3_bus),
    .ad_sample (ad3_sample),
    .ad_vld    (ad3_vld)
  );

  // -------------------------------------------------------------------------
  // combine
  // -------------------------------------------------------------------------
  dsp_combine u_dsp_combine (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .ad1_sample (ad1_sample),
    .ad2_sample (ad2_sample),
    .ad3_sample (ad3_sample),
    .ad1_vld    (ad1_vld),
    .ad2_vld    (ad2_vld),
    .ad3_vld    (ad3_vld),
    .utc_sec    (utc_sec),
    .now_ns     (now_ns),
    .bus        (dsp_bus),
    .dp_data    (dp_data),
    .dp_vld     (dp_vld),
    .dp_sec     (dp_sec),
    .dp_ns      (dp_ns)
  );

endmodule

`default_nettype wire

// ==== logic/wz_cfg_pkg.sv ====
// register map of the acquisition slice
`default_nettype none

package wz_cfg_pkg;

  // bus widths
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // upper address nibble selects the block
  typedef logic [3:0] mod_t;

  localparam mod_t MOD_SYN = 4'd1;
  localparam mod_t MOD_AD1 = 4'd2;
  localparam mod_t MOD_AD2 = 4'd3;
  localparam mod_t MOD_AD3 = 4'd4;
  localparam mod_t MOD_DSP = 4'd5;

  // lower nibble, same offsets in every block
  typedef logic [3:0] reg_t;

  localparam reg_t REG_CTRL = 4'd0;
  localparam reg_t REG_DATA = 4'd1;
  localparam reg_t REG_STAT = 4'd2;

endpackage

`default_nettype wire

// ==== logic/wz_data_pkg.sv ====
// data path types
`default_nettype none

package wz_data_pkg;

  // raw adc word, two's complement
  typedef logic signed [23:0] ad_sample_t;

  // combined word, wide enough for a three-way sum
  typedef logic signed [25:0] dp_sample_t;

  typedef logic [31:0] utc_t;
  typedef logic [31:0] ns_t;

  // one second in nanoseconds
  localparam ns_t NS_PER_SEC = 32'd1_000_000_000;

  typedef enum logic [1:0] {
    DP_CH1 = 2'd0,
    DP_CH2 = 2'd1,
    DP_CH3 = 2'd2,
    DP_SUM = 2'd3
  } dp_mode_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the acquisition slice testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_top_s -f flist.f -o tb_top_s_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_top_s_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

exit 0
